//--- common/surf_ctrl_pkg.sv
`default_nettype none

package surf_ctrl_pkg;

	// Control bus byte address, 20 bits as on the PCI control path.
	typedef logic [19:0] ctrl_addr_t;
	// One bus data word.
	typedef logic [31:0] ctrl_data_t;
	// Board LED drive.
	typedef logic [3:0] led_t;
	// Word index into the sample buffer.
	typedef logic [7:0] buf_index_t;
	// Top four address bits pick a 64 KiB block.
	typedef logic [3:0] blk_sel_t;

	// Block map.
	localparam blk_sel_t BLK_ID = 4'd0;
	localparam blk_sel_t BLK_DMA = 4'd1;
	localparam blk_sel_t BLK_BUF = 4'd2;

	// ID and control block registers.
	localparam logic [15:0] REG_VERSION = 16'h0000;
	localparam logic [15:0] REG_SCRATCH = 16'h0004;
	localparam logic [15:0] REG_CONTROL = 16'h0008;
	localparam logic [15:0] REG_IRQ = 16'h000C;

	// DMA engine registers.
	localparam logic [15:0] DMA_SRC = 16'h0000;
	localparam logic [15:0] DMA_DST = 16'h0004;
	localparam logic [15:0] DMA_COUNT = 16'h0008;
	localparam logic [15:0] DMA_GO = 16'h000C;

	// Firmware version fields, packed in this order into one word.
	localparam logic [3:0] BOARD_REV = 4'h1;
	localparam logic [3:0] FW_MONTH = 4'd8;
	localparam logic [7:0] FW_DAY = 8'd28;
	localparam logic [3:0] FW_MAJOR = 4'd0;
	localparam logic [3:0] FW_MINOR = 4'd5;
	localparam logic [7:0] FW_REVISION = 8'd3;

endpackage

`default_nettype wire

//--- dma/dma_engine.sv
`timescale 1ns/1ns
`default_nettype none

module dma_engine (
	input  wire                        sys_clk,
	input  wire                        reset_i,
	input  wire                        stb_i,
	input  wire                        we_i,
	input  wire surf_ctrl_pkg::ctrl_addr_t adr_i,
	input  wire surf_ctrl_pkg::ctrl_data_t dat_i,
	output surf_ctrl_pkg::ctrl_data_t  dat_o,
	output logic                       ack_o,
	output logic                       m_cyc_o,
	output logic                       m_stb_o,
	output logic                       m_we_o,
	output surf_ctrl_pkg::ctrl_addr_t  m_adr_o,
	output surf_ctrl_pkg::ctrl_data_t  m_dat_o,
	input  wire surf_ctrl_pkg::ctrl_data_t m_dat_i,
	input  wire                        m_ack_i,
	input  wire                        m_err_i,
	output logic                       done_o
);
	import surf_ctrl_pkg::*;

	typedef enum logic [1:0] {DMA_IDLE, DMA_READ, DMA_WRITE, DMA_NEXT} dma_state_t;

	dma_state_t state;
	ctrl_addr_t src;
	ctrl_addr_t dst;
	ctrl_addr_t cur_src;
	ctrl_addr_t cur_dst;
	ctrl_data_t count;
	ctrl_data_t remain;
	ctrl_data_t rd_word;
	logic stb_q;
	logic busy;
	logic acc;
	logic go;
	logic m_done;
	logic abort;
	logic [15:0] reg_off;

	assign reg_off = adr_i[15:0];
	assign acc = stb_i && !ack_o;
	assign busy = (state != DMA_IDLE);
	// GO is ignored while a copy runs.
	assign go = acc && we_i && (reg_off == DMA_GO) && !busy;
	assign m_done = stb_q && m_ack_i;
	assign abort = stb_q && m_err_i;
	// Same edge as busy falling, so the IRQ bit sets with it.
	assign done_o = abort || (state == DMA_NEXT && remain == '0);

	// Register slave.
	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			ack_o <= 1'b0;
			src <= '0;
			dst <= '0;
			count <= '0;
		end else begin
			ack_o <= acc;
			if (acc && we_i) begin
				case (reg_off)
					DMA_SRC: src <= dat_i[19:0];
					DMA_DST: dst <= dat_i[19:0];
					DMA_COUNT: count <= dat_i;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (acc) begin
			case (reg_off)
				DMA_SRC: dat_o <= ctrl_data_t'(src);
				DMA_DST: dat_o <= ctrl_data_t'(dst);
				DMA_COUNT: dat_o <= count;
				DMA_GO: dat_o <= ctrl_data_t'(busy);
				default: dat_o <= '0;
			endcase
		end
	end

	// Copy FSM. Strobe drops for a cycle after every ack.
	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			state <= DMA_IDLE;
			stb_q <= 1'b0;
		end else begin
			case (state)
				DMA_IDLE: begin
					if (go)
						state <= DMA_NEXT;
				end
				DMA_NEXT: begin
					if (remain == '0) begin
						state <= DMA_IDLE;
					end else begin
						state <= DMA_READ;
						stb_q <= 1'b1;
					end
				end
				DMA_READ: begin
					if (abort) begin
						state <= DMA_IDLE;
						stb_q <= 1'b0;
					end else if (m_done) begin
						state <= DMA_WRITE;
						stb_q <= 1'b0;
					end
				end
				DMA_WRITE: begin
					if (abort) begin
						state <= DMA_IDLE;
						stb_q <= 1'b0;
					end else if (m_done) begin
						state <= DMA_NEXT;
						stb_q <= 1'b0;
					end else begin
						// Raise write strobe after the gap cycle.
						stb_q <= 1'b1;
					end
				end
				default: state <= DMA_IDLE;
			endcase
		end
	end

	// Working pointers and the word in flight.
	always_ff @(posedge sys_clk) begin
		if (go) begin
			cur_src <= src;
			cur_dst <= dst;
			remain <= count;
		end
		if (state == DMA_READ && m_done)
			rd_word <= m_dat_i;
		if (state == DMA_WRITE && m_done) begin
			cur_src <= cur_src + ctrl_addr_t'(4);
			cur_dst <= cur_dst + ctrl_addr_t'(4);
			remain <= remain - ctrl_data_t'(1);
		end
	end

	assign m_cyc_o = stb_q;
	assign m_stb_o = stb_q;
	assign m_we_o = (state == DMA_WRITE);
	assign m_adr_o = (state == DMA_WRITE) ? cur_dst : cur_src;
	assign m_dat_o = rd_word;

	a_idle_quiet: assert property (@(posedge sys_clk) disable iff (reset_i)
		(state == DMA_IDLE) |-> !m_stb_o);

endmodule

`default_nettype wire

//--- filelist.f
common/surf_ctrl_pkg.sv
verilog/ctrl_bus_arbiter.sv
verilog/id_ctrl_regs.sv
verilog/sample_buffer.sv
dma/dma_engine.sv
verilog/surf_ctrl_top.sv
tests/tb_surf_ctrl.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --top-module tb_surf_ctrl -f filelist.f -o sim_surf_ctrl \
	> "$LOG" 2>&1 &&
./obj_dir/sim_surf_ctrl >> "$LOG" 2>&1 ||
echo "Simulation finished: FAIL" >> "$LOG"
cat "$LOG"
grep -q "Simulation finished: FAIL" "$LOG" && exit 1 || exit 0

//--- tests/surf_ctrl_testdata.txt
// op addr data expect; ops 1 write, 2 read and compare, 3 expect err, 4 led and osc enable,
// 5 poll addr until it reads expect, 6 irq_o equals expect, 0 end.
4 00000 00000000 00000001
6 00000 00000000 00000000
2 00000 00000000 181C0503
1 00000 DEADBEEF 00000000
2 00000 00000000 181C0503
1 00004 A5A55A5A 00000000
2 00004 00000000 A5A55A5A
3 30000 00000000 00000001
3 F0010 00000000 00000001
1 20000 11111111 00000000
1 203FC 22222222 00000000
2 20000 00000000 11111111
2 203FC 00000000 22222222
1 00008 0000001A 00000000
4 00000 0000000A 00000000
1 00008 00000005 00000000
4 00000 00000005 00000001
// Source words for the DMA copy, buffer index 16 up.
1 20040 C0DE0010 00000000
1 20044 3C5A0011 00000000
1 20048 FFFF0012 00000000
1 2004C 00000013 00000000
1 20050 8001E014 00000000
1 20054 7F7F0015 00000000
1 20058 12340016 00000000
1 2005C ABCD0017 00000000
1 10000 00020040 00000000
1 10004 00020100 00000000
1 10008 00000008 00000000
1 1000C 00000001 00000000
5 1000C 00000000 00000000
6 00000 00000000 00000000
2 0000C 00000000 00000001
2 20100 00000000 C0DE0010
2 20104 00000000 3C5A0011
2 20108 00000000 FFFF0012
2 2010C 00000000 00000013
2 20110 00000000 8001E014
2 20114 00000000 7F7F0015
2 20118 00000000 12340016
2 2011C 00000000 ABCD0017
1 0000C 00000001 00000000
6 00000 00000000 00000000
1 00008 00000025 00000000
6 00000 00000000 00000000
1 1000C 00000001 00000000
5 1000C 00000000 00000000
6 00000 00000000 00000001
1 0000C 00000001 00000000
6 00000 00000000 00000000
0 00000 00000000 00000000

//--- tests/tb_surf_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_surf_ctrl;
	import surf_ctrl_pkg::*;

	localparam int MAX_OPS = 64;
	// Op codes of the test data file.
	localparam int OP_END = 0;
	localparam int OP_WRITE = 1;
	localparam int OP_READ = 2;
	localparam int OP_ERR = 3;
	localparam int OP_LED = 4;
	localparam int OP_WAIT_IRQ = 5;
	localparam int OP_IRQ = 6;

	logic sys_clk;
	logic reset_i;
	logic host_cyc;
	logic host_stb;
	logic host_we;
	ctrl_addr_t host_adr;
	ctrl_data_t host_wdat;
	ctrl_data_t host_rdat;
	logic host_ack;
	logic host_err;
	led_t led;
	logic osc_en;
	logic irq;

	// Four words per op: op code, address, write data, expected value.
	logic [31:0] vec [0:MAX_OPS*4-1];
	int n_ops;
	int errors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	surf_ctrl_top dut_i (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.host_cyc_i(host_cyc),
		.host_stb_i(host_stb),
		.host_we_i(host_we),
		.host_adr_i(host_adr),
		.host_dat_i(host_wdat),
		.host_dat_o(host_rdat),
		.host_ack_o(host_ack),
		.host_err_o(host_err),
		.led_o(led),
		.local_osc_en_o(osc_en),
		.irq_o(irq)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// Run length guard, limit set once the op count is known.
	always @(posedge sys_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("ERROR: timeout after %0d cycles, the bus never finished", cycle_count);
			$display("Simulation finished: FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_data(input ctrl_data_t got, input ctrl_data_t exp, input string what);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_led(input led_t got, input led_t exp, input string what);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_mismatch(what, 32'(got), 32'(exp));
	endtask

	// One host cycle; stb raised on a falling edge and held until ack or err.
	task automatic bus_access(input logic we, input ctrl_addr_t adr, input ctrl_data_t wdat,
			output ctrl_data_t rdat, output logic ack, output logic err);
		@(negedge sys_clk);
		host_cyc = 1'b1;
		host_stb = 1'b1;
		host_we = we;
		host_adr = adr;
		host_wdat = wdat;
		do
			@(negedge sys_clk);
		while (!(host_ack || host_err));
		rdat = host_rdat;
		ack = host_ack;
		err = host_err;
		// Drop the strobe, the next access leaves a gap cycle.
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
	endtask

	task automatic run_op(input int idx);
		logic [31:0] op;
		ctrl_addr_t adr;
		ctrl_data_t wdat;
		ctrl_data_t exp;
		ctrl_data_t rdat;
		logic ack;
		logic err;
		op = vec[idx*4];
		adr = vec[idx*4+1][19:0];
		wdat = vec[idx*4+2];
		exp = vec[idx*4+3];
		case (op)
			OP_WRITE: begin
				bus_access(1'b1, adr, wdat, rdat, ack, err);
				check_bit(err, 1'b0, "write err");
			end
			OP_READ: begin
				bus_access(1'b0, adr, '0, rdat, ack, err);
				check_bit(err, 1'b0, "read err");
				check_data(rdat, exp, "read data");
			end
			OP_ERR: begin
				bus_access(1'b0, adr, '0, rdat, ack, err);
				check_bit(ack, 1'b0, "unmapped ack");
				check_bit(err, 1'b1, "unmapped err");
			end
			OP_LED: begin
				@(negedge sys_clk);
				check_led(led, wdat[3:0], "led_o");
				check_bit(osc_en, exp[0], "local_osc_en_o");
			end
			OP_WAIT_IRQ: begin
				// Poll the busy bit, every poll must end with ack.
				do begin
					bus_access(1'b0, adr, '0, rdat, ack, err);
					check_bit(ack, 1'b1, "poll ack");
				end while (rdat !== exp);
			end
			OP_IRQ: begin
				@(negedge sys_clk);
				check_bit(irq, exp[0], "irq_o");
			end
			default: begin
				$display("ERROR: unknown op code %h at op %0d of the test data", op, idx);
				$display("Simulation finished: FAIL");
				$fatal(1, "bad test data");
			end
		endcase
	endtask

	initial begin
		int i;
		reset_i = 1'b1;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_wdat = '0;
		for (i = 0; i < MAX_OPS * 4; i++)
			vec[i] = '0;
		$readmemh("tests/surf_ctrl_testdata.txt", vec);
		n_ops = 0;
		while (n_ops < MAX_OPS && vec[n_ops*4] != OP_END)
			n_ops++;
		cycle_limit = n_ops * 64 + 4096;
		// Reset over ten rising edges.
		repeat (10) @(negedge sys_clk);
		reset_i = 1'b0;
		for (i = 0; i < n_ops; i++)
			run_op(i);
		repeat (2) @(negedge sys_clk);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/ctrl_bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module ctrl_bus_arbiter (
	input  wire                        sys_clk,
	input  wire                        reset_i,
	input  wire                        host_cyc_i,
	input  wire                        host_stb_i,
	input  wire                        host_we_i,
	input  wire surf_ctrl_pkg::ctrl_addr_t host_adr_i,
	input  wire surf_ctrl_pkg::ctrl_data_t host_dat_i,
	output surf_ctrl_pkg::ctrl_data_t  host_dat_o,
	output logic                       host_ack_o,
	output logic                       host_err_o,
	input  wire                        dma_cyc_i,
	input  wire                        dma_stb_i,
	input  wire                        dma_we_i,
	input  wire surf_ctrl_pkg::ctrl_addr_t dma_adr_i,
	input  wire surf_ctrl_pkg::ctrl_data_t dma_dat_i,
	output surf_ctrl_pkg::ctrl_data_t  dma_dat_o,
	output logic                       dma_ack_o,
	output logic                       dma_err_o,
	output logic                       slv_we_o,
	output surf_ctrl_pkg::ctrl_addr_t  slv_adr_o,
	output surf_ctrl_pkg::ctrl_data_t  slv_dat_o,
	output logic                       id_stb_o,
	output logic                       dmar_stb_o,
	output logic                       buf_stb_o,
	input  wire surf_ctrl_pkg::ctrl_data_t id_dat_i,
	input  wire                        id_ack_i,
	input  wire surf_ctrl_pkg::ctrl_data_t dmar_dat_i,
	input  wire                        dmar_ack_i,
	input  wire surf_ctrl_pkg::ctrl_data_t buf_dat_i,
	input  wire                        buf_ack_i
);
	import surf_ctrl_pkg::*;

	typedef enum logic [1:0] {ARB_IDLE, ARB_HOST, ARB_DMA} arb_state_t;

	arb_state_t state;
	logic last_dma;
	logic host_req;
	logic dma_req;
	logic host_gnt;
	logic dma_gnt;
	logic own_stb;
	logic unmapped;
	logic err_q;
	logic rd_ack;
	blk_sel_t blk;
	ctrl_data_t rd_dat;

	assign host_req = host_cyc_i && host_stb_i;
	assign dma_req = dma_cyc_i && dma_stb_i;
	assign host_gnt = (state == ARB_HOST);
	assign dma_gnt = (state == ARB_DMA);

	// Owner's request goes onto the shared slave side.
	always_comb begin
		slv_we_o = 1'b0;
		slv_adr_o = '0;
		slv_dat_o = '0;
		own_stb = 1'b0;
		if (host_gnt) begin
			slv_we_o = host_we_i;
			slv_adr_o = host_adr_i;
			slv_dat_o = host_dat_i;
			own_stb = host_req;
		end else if (dma_gnt) begin
			slv_we_o = dma_we_i;
			slv_adr_o = dma_adr_i;
			slv_dat_o = dma_dat_i;
			own_stb = dma_req;
		end
	end

	// Block decode.
	assign blk = slv_adr_o[19:16];
	assign unmapped = !(blk inside {BLK_ID, BLK_DMA, BLK_BUF});
	assign id_stb_o = own_stb && (blk == BLK_ID);
	assign dmar_stb_o = own_stb && (blk == BLK_DMA);
	assign buf_stb_o = own_stb && (blk == BLK_BUF);

	// Return path from the addressed slave.
	always_comb begin
		rd_dat = '0;
		rd_ack = 1'b0;
		case (blk)
			BLK_ID: begin
				rd_dat = id_dat_i;
				rd_ack = id_ack_i;
			end
			BLK_DMA: begin
				rd_dat = dmar_dat_i;
				rd_ack = dmar_ack_i;
			end
			BLK_BUF: begin
				rd_dat = buf_dat_i;
				rd_ack = buf_ack_i;
			end
			default: ;
		endcase
	end

	// An unmapped block gets a one cycle err in the slot of a slave ack.
	always_ff @(posedge sys_clk) begin
		if (reset_i)
			err_q <= 1'b0;
		else
			err_q <= own_stb && unmapped && !err_q;
	end

	// Grant FSM; on a tie the master not served last wins.
	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			state <= ARB_IDLE;
			last_dma <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (host_req && (!dma_req || last_dma)) begin
						state <= ARB_HOST;
						last_dma <= 1'b0;
					end else if (dma_req) begin
						state <= ARB_DMA;
						last_dma <= 1'b1;
					end
				end
				ARB_HOST, ARB_DMA: begin
					if (rd_ack || err_q)
						state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Only the owner sees data and the handshake.
	assign host_dat_o = host_gnt ? rd_dat : '0;
	assign host_ack_o = host_gnt && rd_ack;
	assign host_err_o = host_gnt && err_q;
	assign dma_dat_o = dma_gnt ? rd_dat : '0;
	assign dma_ack_o = dma_gnt && rd_ack;
	assign dma_err_o = dma_gnt && err_q;

	// One owner and one addressed slave at a time.
	a_one_grant: assert property (@(posedge sys_clk) disable iff (reset_i)
		!(host_gnt && dma_gnt));
	a_one_strobe: assert property (@(posedge sys_clk) disable iff (reset_i)
		$onehot0({id_stb_o, dmar_stb_o, buf_stb_o}));

endmodule

`default_nettype wire

//--- verilog/id_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module id_ctrl_regs #(
	parameter surf_ctrl_pkg::ctrl_data_t VERSION = 32'h0
) (
	input  wire                        sys_clk,
	input  wire                        reset_i,
	input  wire                        stb_i,
	input  wire                        we_i,
	input  wire surf_ctrl_pkg::ctrl_addr_t adr_i,
	input  wire surf_ctrl_pkg::ctrl_data_t dat_i,
	output surf_ctrl_pkg::ctrl_data_t  dat_o,
	output logic                       ack_o,
	input  wire                        dma_done_i,
	output surf_ctrl_pkg::led_t        led_o,
	output logic                       local_osc_en_o,
	output logic                       irq_o
);
	import surf_ctrl_pkg::*;

	// Control register bits above the LEDs.
	localparam int CTL_OSC_DIS = 4;
	localparam int CTL_IRQ_EN = 5;

	ctrl_data_t scratch;
	logic [5:0] control;
	logic irq_stat;
	logic acc;
	logic wr_en;
	logic [15:0] reg_off;

	assign reg_off = adr_i[15:0];
	// New access only when no ack is out.
	assign acc = stb_i && !ack_o;
	assign wr_en = acc && we_i;

	always_ff @(posedge sys_clk) begin
		if (reset_i)
			ack_o <= 1'b0;
		else
			ack_o <= acc;
	end

	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			control <= '0;
			irq_stat <= 1'b0;
		end else begin
			if (wr_en && reg_off == REG_CONTROL)
				control <= dat_i[5:0];
			// DMA done wins over a clear in the same cycle.
			if (dma_done_i)
				irq_stat <= 1'b1;
			else if (wr_en && reg_off == REG_IRQ && dat_i[0])
				irq_stat <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en && reg_off == REG_SCRATCH)
			scratch <= dat_i;
		if (acc) begin
			case (reg_off)
				REG_VERSION: dat_o <= VERSION;
				REG_SCRATCH: dat_o <= scratch;
				REG_CONTROL: dat_o <= ctrl_data_t'(control);
				REG_IRQ: dat_o <= ctrl_data_t'(irq_stat);
				default: dat_o <= '0;
			endcase
		end
	end

	assign led_o = control[3:0];
	// Bit set means oscillator off.
	assign local_osc_en_o = !control[CTL_OSC_DIS];
	assign irq_o = irq_stat && control[CTL_IRQ_EN];

endmodule

`default_nettype wire

//--- verilog/sample_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module sample_buffer #(
	parameter int BUF_DEPTH_LOG2 = 8
) (
	input  wire                        sys_clk,
	input  wire                        reset_i,
	input  wire                        stb_i,
	input  wire                        we_i,
	input  wire surf_ctrl_pkg::ctrl_addr_t adr_i,
	input  wire surf_ctrl_pkg::ctrl_data_t dat_i,
	output surf_ctrl_pkg::ctrl_data_t  dat_o,
	output logic                       ack_o
);
	import surf_ctrl_pkg::*;

	localparam int DEPTH = 2 ** BUF_DEPTH_LOG2;

	ctrl_data_t mem [DEPTH];
	logic [BUF_DEPTH_LOG2-1:0] idx;
	logic acc;

	// Word index, byte offset dropped.
	assign idx = adr_i[BUF_DEPTH_LOG2+1:2];
	assign acc = stb_i && !ack_o;

	// Block RAM style port, read returns old data on a write.
	always_ff @(posedge sys_clk) begin
		if (acc) begin
			if (we_i)
				mem[idx] <= dat_i;
			dat_o <= mem[idx];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (reset_i)
			ack_o <= 1'b0;
		else
			ack_o <= acc;
	end

endmodule

`default_nettype wire

//--- verilog/surf_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module surf_ctrl_top #(
	parameter surf_ctrl_pkg::ctrl_data_t VERSION = {
		surf_ctrl_pkg::BOARD_REV, surf_ctrl_pkg::FW_MONTH, surf_ctrl_pkg::FW_DAY,
		surf_ctrl_pkg::FW_MAJOR, surf_ctrl_pkg::FW_MINOR, surf_ctrl_pkg::FW_REVISION},
	parameter int BUF_DEPTH_LOG2 = 8
) (
	input  wire                        sys_clk,
	input  wire                        reset_i,
	input  wire                        host_cyc_i,
	input  wire                        host_stb_i,
	input  wire                        host_we_i,
	input  wire surf_ctrl_pkg::ctrl_addr_t host_adr_i,
	input  wire surf_ctrl_pkg::ctrl_data_t host_dat_i,
	output surf_ctrl_pkg::ctrl_data_t  host_dat_o,
	output logic                       host_ack_o,
	output logic                       host_err_o,
	output surf_ctrl_pkg::led_t        led_o,
	output logic                       local_osc_en_o,
	output logic                       irq_o
);
	import surf_ctrl_pkg::*;

	// DMA master port.
	logic dma_cyc;
	logic dma_stb;
	logic dma_we;
	ctrl_addr_t dma_adr;
	ctrl_data_t dma_wdat;
	ctrl_data_t dma_rdat;
	logic dma_ack;
	logic dma_err;
	// Shared slave side.
	logic slv_we;
	ctrl_addr_t slv_adr;
	ctrl_data_t slv_dat;
	logic id_stb;
	logic dmar_stb;
	logic buf_stb;
	ctrl_data_t id_dat;
	ctrl_data_t dmar_dat;
	ctrl_data_t buf_dat;
	logic id_ack;
	logic dmar_ack;
	logic buf_ack;
	logic dma_done;

	ctrl_bus_arbiter u_arbiter (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.host_cyc_i(host_cyc_i),
		.host_stb_i(host_stb_i),
		.host_we_i(host_we_i),
		.host_adr_i(host_adr_i),
		.host_dat_i(host_dat_i),
		.host_dat_o(host_dat_o),
		.host_ack_o(host_ack_o),
		.host_err_o(host_err_o),
		.dma_cyc_i(dma_cyc),
		.dma_stb_i(dma_stb),
		.dma_we_i(dma_we),
		.dma_adr_i(dma_adr),
		.dma_dat_i(dma_wdat),
		.dma_dat_o(dma_rdat),
		.dma_ack_o(dma_ack),
		.dma_err_o(dma_err),
		.slv_we_o(slv_we),
		.slv_adr_o(slv_adr),
		.slv_dat_o(slv_dat),
		.id_stb_o(id_stb),
		.dmar_stb_o(dmar_stb),
		.buf_stb_o(buf_stb),
		.id_dat_i(id_dat),
		.id_ack_i(id_ack),
		.dmar_dat_i(dmar_dat),
		.dmar_ack_i(dmar_ack),
		.buf_dat_i(buf_dat),
		.buf_ack_i(buf_ack)
	);

	// Block 0.
	id_ctrl_regs #(.VERSION(VERSION)) u_id_ctrl (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.stb_i(id_stb),
		.we_i(slv_we),
		.adr_i(slv_adr),
		.dat_i(slv_dat),
		.dat_o(id_dat),
		.ack_o(id_ack),
		.dma_done_i(dma_done),
		.led_o(led_o),
		.local_osc_en_o(local_osc_en_o),
		.irq_o(irq_o)
	);

	// Block 1, also the second bus master.
	dma_engine u_dma (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.stb_i(dmar_stb),
		.we_i(slv_we),
		.adr_i(slv_adr),
		.dat_i(slv_dat),
		.dat_o(dmar_dat),
		.ack_o(dmar_ack),
		.m_cyc_o(dma_cyc),
		.m_stb_o(dma_stb),
		.m_we_o(dma_we),
		.m_adr_o(dma_adr),
		.m_dat_o(dma_wdat),
		.m_dat_i(dma_rdat),
		.m_ack_i(dma_ack),
		.m_err_i(dma_err),
		.done_o(dma_done)
	);

	// Block 2.
	sample_buffer #(.BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)) u_buf (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.stb_i(buf_stb),
		.we_i(slv_we),
		.adr_i(slv_adr),
		.dat_i(slv_dat),
		.dat_o(buf_dat),
		.ack_o(buf_ack)
	);

endmodule

`default_nettype wire
